// File: common/vdp_pkg.sv
package vdp_pkg;

    // counter and data widths
    typedef logic [9:0]  hcount_t;          // horizontal pixel counter
    typedef logic [9:0]  vcount_t;          // vertical line counter
    typedef logic [11:0] vram_addr_t;       // host byte address into the 4k vram
    typedef logic [7:0]  vram_data_t;       // one vram byte
    typedef logic [9:0]  name_addr_t;       // name table index
    typedef logic [10:0] pattern_addr_t;    // pattern table index
    typedef logic [4:0]  color_addr_t;      // color table index
    typedef logic [3:0]  color_idx_t;       // palette index

    // horizontal geometry in pixel clocks
    localparam int h_total      = 800;
    localparam int h_visible    = 640;
    localparam int h_sync_start = 656;
    localparam int h_sync_len   = 96;

    // vertical geometry in lines
    localparam int v_total      = 525;
    localparam int v_visible    = 480;
    localparam int v_sync_start = 490;
    localparam int v_sync_len   = 2;

    // tile area, 32x24 tiles of 8x8 doubled pixels
    localparam int disp_width   = 512;
    localparam int disp_height  = 384;

    // vram layout
    localparam int         vram_bytes   = 4096;
    localparam vram_addr_t name_base    = 12'h000;  // 768 bytes
    localparam vram_addr_t color_base   = 12'h300;  // 32 bytes, one per 8 characters
    localparam vram_addr_t pattern_base = 12'h800;  // 2048 bytes, 8 per character

endpackage

// File: common/video_timing_if.sv
interface video_timing_if
    import vdp_pkg::*;
;

    logic    hsync;     // active high inside the design
    logic    vsync;
    hcount_t col;       // column relative to the tile area
    vcount_t row;       // row relative to the tile area
    logic    active;    // inside the visible 640x480
    logic    border;    // visible but outside the tile area

    modport source (
        output hsync, vsync, col, row, active, border
    );

    modport sink (
        input hsync, vsync, col, row, active, border
    );

endinterface

// File: common/vram_read_if.sv
interface vram_read_if
    import vdp_pkg::*;
;

    // each read returns its byte one clock after the address
    name_addr_t    name_raddr;
    pattern_addr_t pattern_raddr;
    color_addr_t   color_raddr;
    vram_data_t    name_rdata;
    vram_data_t    pattern_rdata;
    vram_data_t    color_rdata;

    modport render (
        output name_raddr, pattern_raddr, color_raddr,
        input  name_rdata, pattern_rdata, color_rdata
    );

    modport mem (
        input  name_raddr, pattern_raddr, color_raddr,
        output name_rdata, pattern_rdata, color_rdata
    );

endinterface

// File: verilog/vga_timing.sv
module vga_timing
    import vdp_pkg::*;
#(
    parameter int hlb = 64,     // left border width
    parameter int vtb = 48      // top border height
) (
    input  logic           pxclk,
    input  logic           rst,
    video_timing_if.source vt
);

    hcount_t hcount;
    vcount_t vcount;
    logic    h_end;
    logic    v_end;
    logic    hsync_next;
    logic    vsync_next;
    logic    visible;
    logic    in_tile_h;
    logic    in_tile_v;

    assign h_end = (hcount == hcount_t'(h_total - 1));
    assign v_end = (vcount == vcount_t'(v_total - 1));

    // frame counters, both zero while rst is held
    always_ff @(posedge pxclk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
        end else begin
            if (h_end) begin
                hcount <= '0;
                if (v_end) begin
                    vcount <= '0;
                end else begin
                    vcount <= vcount + 1'b1;
                end
            end else begin
                hcount <= hcount + 1'b1;
            end
        end
    end

    assign hsync_next = (hcount >= hcount_t'(h_sync_start)) &&
                        (hcount < hcount_t'(h_sync_start + h_sync_len));
    assign vsync_next = (vcount >= vcount_t'(v_sync_start)) &&
                        (vcount < vcount_t'(v_sync_start + v_sync_len));
    assign visible    = (hcount < hcount_t'(h_visible)) && (vcount < vcount_t'(v_visible));

    assign in_tile_h = (hcount >= hcount_t'(hlb)) && (hcount < hcount_t'(hlb + disp_width));
    assign in_tile_v = (vcount >= vcount_t'(vtb)) && (vcount < vcount_t'(vtb + disp_height));

    // registered flags, one cycle behind the counters
    always_ff @(posedge pxclk) begin
        if (rst) begin
            vt.hsync  <= 1'b0;
            vt.vsync  <= 1'b0;
            vt.active <= 1'b0;
            vt.border <= 1'b0;
        end else begin
            vt.hsync  <= hsync_next;
            vt.vsync  <= vsync_next;
            vt.active <= visible;
            vt.border <= visible && !(in_tile_h && in_tile_v);
        end
    end

    // coordinates wrap below zero in the border, renderer ignores them there
    always_ff @(posedge pxclk) begin
        vt.col <= hcount - hcount_t'(hlb);
        vt.row <= vcount - vcount_t'(vtb);
    end

    // tile-area pixels must address a valid column
    a_col_in_tile : assert property (
        @(posedge pxclk) disable iff (rst)
        (vt.active && !vt.border) |-> (vt.col < hcount_t'(disp_width))
    );

endmodule

// File: vdp/vdp_tile_render.sv
module vdp_tile_render
    import vdp_pkg::*;
#(
    parameter color_idx_t backdrop = 4'd4   // border color
) (
    input  logic         pxclk,
    input  logic         rst,
    video_timing_if.sink vt,
    vram_read_if.render  mem,
    output logic         red,
    output logic         grn,
    output logic         blu,
    output logic         hsync,     // delayed to match the pixels
    output logic         vsync
);

    // stage 1 state, name read in flight
    logic       hsync_s1;
    logic       vsync_s1;
    logic       active_s1;
    logic       border_s1;
    logic [2:0] bit_s1;     // pattern bit to pick, 7 is leftmost
    logic [2:0] line_s1;    // line within the pattern

    // stage 2 state, pattern and color reads in flight
    logic       hsync_s2;
    logic       vsync_s2;
    logic       active_s2;
    logic       border_s2;
    logic [2:0] bit_s2;

    // stage 3 pixel choice
    logic       pix_on;
    color_idx_t tile_color;
    color_idx_t pix_color;

    // stage 1: 32 names per tile row, each tile 16 screen pixels wide
    assign mem.name_raddr = {vt.row[8:4], vt.col[8:4]};

    always_ff @(posedge pxclk) begin
        if (rst) begin
            hsync_s1  <= 1'b0;
            vsync_s1  <= 1'b0;
            active_s1 <= 1'b0;
            border_s1 <= 1'b0;
        end else begin
            hsync_s1  <= vt.hsync;
            vsync_s1  <= vt.vsync;
            active_s1 <= vt.active;
            border_s1 <= vt.border;
        end
    end

    always_ff @(posedge pxclk) begin
        bit_s1  <= 3'd7 - vt.col[3:1];  // pixels doubled, so drop col[0]
        line_s1 <= vt.row[3:1];
    end

    // stage 2: name byte selects the pattern and its color group
    assign mem.pattern_raddr = {mem.name_rdata, line_s1};
    assign mem.color_raddr   = mem.name_rdata[7:3];

    always_ff @(posedge pxclk) begin
        if (rst) begin
            hsync_s2  <= 1'b0;
            vsync_s2  <= 1'b0;
            active_s2 <= 1'b0;
            border_s2 <= 1'b0;
        end else begin
            hsync_s2  <= hsync_s1;
            vsync_s2  <= vsync_s1;
            active_s2 <= active_s1;
            border_s2 <= border_s1;
        end
    end

    always_ff @(posedge pxclk) begin
        bit_s2 <= bit_s1;
    end

    // stage 3: foreground in the high nibble, background in the low
    assign pix_on     = mem.pattern_rdata[bit_s2];
    assign tile_color = pix_on ? mem.color_rdata[7:4] : mem.color_rdata[3:0];

    always_comb begin
        if (!active_s2) begin
            pix_color = '0;             // blanking is black
        end else if (border_s2) begin
            pix_color = backdrop;
        end else begin
            pix_color = tile_color;
        end
    end

    always_ff @(posedge pxclk) begin
        if (rst) begin
            red   <= 1'b0;
            grn   <= 1'b0;
            blu   <= 1'b0;
            hsync <= 1'b0;
            vsync <= 1'b0;
        end else begin
            red   <= pix_color[2];
            grn   <= pix_color[1];
            blu   <= pix_color[0];
            hsync <= hsync_s2;
            vsync <= vsync_s2;
        end
    end

    // nothing visible may leak into blanking
    a_blank_black : assert property (
        @(posedge pxclk) disable iff (rst)
        !active_s2 |=> !(red || grn || blu)
    );

endmodule

// File: vdp/vdp_vram.sv
module vdp_vram
    import vdp_pkg::*;
(
    input  logic       pxclk,
    input  logic       wr_en,
    input  vram_addr_t wr_addr,
    input  vram_data_t wr_data,
    vram_read_if.mem   mem
);

    vram_data_t ram [vram_bytes];

    vram_addr_t name_addr;
    vram_addr_t pattern_addr;
    vram_addr_t color_addr;

    // table indices become byte addresses
    assign name_addr    = name_base + vram_addr_t'(mem.name_raddr);
    assign pattern_addr = pattern_base + vram_addr_t'(mem.pattern_raddr);
    assign color_addr   = color_base + vram_addr_t'(mem.color_raddr);

    // host side, a single strobe per byte
    always_ff @(posedge pxclk) begin
        if (wr_en) begin
            ram[wr_addr] <= wr_data;
        end
    end

    // display side, all three reads registered
    always_ff @(posedge pxclk) begin
        mem.name_rdata    <= ram[name_addr];
        mem.pattern_rdata <= ram[pattern_addr];
        mem.color_rdata   <= ram[color_addr];
    end

endmodule

// File: verilog/tile_display.sv
module tile_display
    import vdp_pkg::*;
#(
    parameter int         hlb      = 64,    // left border width
    parameter int         vtb      = 48,    // top border height
    parameter color_idx_t backdrop = 4'd4
) (
    input  logic       pxclk,
    input  logic       rst,
    input  logic       wr_en,
    input  vram_addr_t wr_addr,
    input  vram_data_t wr_data,
    output logic       red,
    output logic       grn,
    output logic       blu,
    output logic       hsync_n,
    output logic       vsync_n
);

    logic vdp_hsync;
    logic vdp_vsync;

    video_timing_if vt ();
    vram_read_if    vr ();

    vga_timing #(
        .hlb (hlb),
        .vtb (vtb)
    ) timing_i (
        .pxclk (pxclk),
        .rst   (rst),
        .vt    (vt.source)
    );

    vdp_tile_render #(
        .backdrop (backdrop)
    ) render_i (
        .pxclk (pxclk),
        .rst   (rst),
        .vt    (vt.sink),
        .mem   (vr.render),
        .red   (red),
        .grn   (grn),
        .blu   (blu),
        .hsync (vdp_hsync),
        .vsync (vdp_vsync)
    );

    vdp_vram vram_i (
        .pxclk   (pxclk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .mem     (vr.mem)
    );

    // 640x480 uses negative sync pulses
    assign hsync_n = ~vdp_hsync;
    assign vsync_n = ~vdp_vsync;

endmodule

// File: tests/tile_display_model.svh
`ifndef tile_display_model_svh
`define tile_display_model_svh

// expected color bits at frame position (h, v), red in bit 2
function automatic logic [2:0] model_rgb(input int h, input int v);
    int         col;
    int         row;
    int         name;
    int         bit_pos;
    vram_data_t pattern;
    vram_data_t color;
    color_idx_t idx;
    if (h >= h_visible || v >= v_visible) begin
        return 3'b000;                      // blanking
    end
    col = h - left_border;
    row = v - top_border;
    if (col < 0 || col >= disp_width || row < 0 || row >= disp_height) begin
        return backdrop_idx[2:0];
    end
    name    = vram_copy[int'(name_base) + (row / 16) * 32 + col / 16];
    pattern = vram_copy[int'(pattern_base) + name * 8 + (row % 16) / 2];
    color   = vram_copy[int'(color_base) + name / 8];
    bit_pos = 7 - (col % 16) / 2;           // leftmost pixel is bit 7
    idx     = pattern[bit_pos] ? color[7:4] : color[3:0];
    return idx[2:0];
endfunction

// both syncs are active low at the pins
function automatic logic model_hsync_n(input int h);
    return !(h >= h_sync_start && h < h_sync_start + h_sync_len);
endfunction

function automatic logic model_vsync_n(input int v);
    return !(v >= v_sync_start && v < v_sync_start + v_sync_len);
endfunction

`endif

// File: tests/tile_display_tb.sv
module tile_display_tb
    import vdp_pkg::*;
;

    localparam int         left_border  = 64;
    localparam int         top_border   = 48;
    localparam color_idx_t backdrop_idx = 4'd4;
    localparam int         frame_cycles = h_total * v_total;
    localparam int         pipe_delay   = 4;    // counter to pixel pins
    localparam int         max_wait     = 2 * frame_cycles;
    localparam int         n_samples    = 37;

    typedef enum logic [1:0] {
        sample_pix,     // color and syncs against the model
        sample_sync,    // syncs only
        sample_twin     // like sample_pix and equal to the previous sample
    } kind_t;

    typedef struct packed {
        int    h;
        int    v;
        kind_t kind;
    } sample_t;

    // frame 1 positions in the order the beam reaches them
    sample_t samples [n_samples] = '{
        '{655, 10, sample_sync}, '{656, 10, sample_sync}, '{751, 10, sample_sync},
        '{752, 10, sample_sync}, '{300, 20, sample_pix},  '{64, 47, sample_pix},
        '{63, 48, sample_pix},   '{64, 48, sample_pix},   '{575, 48, sample_pix},
        '{576, 48, sample_pix},  '{10, 100, sample_pix},  '{64, 100, sample_pix},
        '{66, 100, sample_pix},  '{68, 100, sample_pix},  '{70, 100, sample_pix},
        '{72, 100, sample_pix},  '{74, 100, sample_pix},  '{76, 100, sample_pix},
        '{78, 100, sample_pix},  '{600, 100, sample_pix}, '{700, 100, sample_pix},
        '{230, 165, sample_pix}, '{200, 200, sample_pix}, '{201, 200, sample_twin},
        '{300, 250, sample_pix}, '{300, 251, sample_twin}, '{645, 300, sample_pix},
        '{64, 431, sample_pix},  '{575, 431, sample_pix}, '{300, 432, sample_pix},
        '{300, 450, sample_pix}, '{100, 489, sample_sync}, '{0, 490, sample_sync},
        '{100, 490, sample_sync}, '{799, 491, sample_sync}, '{0, 492, sample_sync},
        '{300, 495, sample_pix}
    };

    logic       pxclk;
    logic       rst;
    logic       wr_en;
    vram_addr_t wr_addr;
    vram_data_t wr_data;
    logic       red;
    logic       grn;
    logic       blu;
    logic       hsync_n;
    logic       vsync_n;

    vram_data_t  vram_copy [vram_bytes];   // what the host has written
    longint      cyc;                      // clock edges since rst fell
    int unsigned seed_val;

    `include "tile_display_model.svh"

    tile_display dut_i (
        .pxclk   (pxclk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .red     (red),
        .grn     (grn),
        .blu     (blu),
        .hsync_n (hsync_n),
        .vsync_n (vsync_n)
    );

    initial begin
        pxclk = 1'b0;
        forever #50 pxclk = ~pxclk;
    end

    task automatic stop_on_failure();
        $display("Test FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [2:0] expected,
                                   input logic [2:0] actual);
        $display("[FAIL] time %0t: %s expected %b, got %b", $time, name, expected, actual);
        stop_on_failure();
    endtask

    task automatic report_problem(input string what);
        $display("ERROR at time %0t: %s", $time, what);
        stop_on_failure();
    endtask

    task automatic check_value(input string name, input logic [2:0] expected,
                               input logic [2:0] actual);
        assert (actual === expected) else report_mismatch(name, expected, actual);
    endtask

    task automatic check_syncs(input int h, input int v);
        check_value("hsync_n", {2'b00, model_hsync_n(h)}, {2'b00, hsync_n});
        check_value("vsync_n", {2'b00, model_vsync_n(v)}, {2'b00, vsync_n});
    endtask

    task automatic check_rgb(input int h, input int v);
        logic [2:0] exp_rgb;
        exp_rgb = model_rgb(h, v);
        check_value("red", {2'b00, exp_rgb[2]}, {2'b00, red});
        check_value("grn", {2'b00, exp_rgb[1]}, {2'b00, grn});
        check_value("blu", {2'b00, exp_rgb[0]}, {2'b00, blu});
    endtask

    task automatic step_clock();
        @(posedge pxclk);
        cyc = cyc + 1;
    endtask

    // run to clock edge number target and settle on the next falling edge
    task automatic wait_until(input longint target);
        int waited;
        waited = 0;
        if (cyc >= target) begin
            report_problem("sample positions are not in frame order");
        end
        while (cyc < target) begin
            step_clock();
            waited = waited + 1;
            if (waited > max_wait) begin
                report_problem("timed out waiting for a frame position");
            end
        end
        @(negedge pxclk);
    endtask

    task automatic write_vram(input int addr, input vram_data_t data);
        step_clock();
        wr_en   <= 1'b1;
        wr_addr <= vram_addr_t'(addr);
        wr_data <= data;
        vram_copy[addr] = data;
    endtask

    task automatic end_writes();
        step_clock();
        wr_en <= 1'b0;
    endtask

    initial begin
        logic [2:0] prev_rgb;
        logic [2:0] old_rgb;
        vram_data_t old_name;
        vram_data_t new_name;
        logic       found;
        int         name_idx;
        seed_val = $urandom(53);
        rst      = 1'b1;
        wr_en    = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        cyc      = 0;
        prev_rgb = '0;
        for (int i = 0; i < 10; i++) begin
            @(posedge pxclk);
            if (i == 9) begin
                rst <= 1'b0;                // counters start at zero after this edge
            end
            @(negedge pxclk);
            check_value("red", 3'b000, {2'b00, red});
            check_value("grn", 3'b000, {2'b00, grn});
            check_value("blu", 3'b000, {2'b00, blu});
            check_value("hsync_n", 3'b001, {2'b00, hsync_n});
            check_value("vsync_n", 3'b001, {2'b00, vsync_n});
        end
        cyc = 0;

        for (int a = 0; a < vram_bytes; a++) begin
            write_vram(a, vram_data_t'($urandom));
        end
        // pattern byte under line 100 of the first tile column gets both bit values
        name_idx = (100 - top_border) / 16 * 32;
        write_vram(int'(pattern_base) + vram_copy[name_idx] * 8 + 2, 8'h5a);
        // foreground and background differ in every color bit
        write_vram(int'(color_base) + vram_copy[name_idx] / 8, 8'h61);
        end_writes();

        for (int i = 0; i < n_samples; i++) begin
            wait_until(frame_cycles + samples[i].v * h_total + samples[i].h + pipe_delay);
            check_syncs(samples[i].h, samples[i].v);
            if (samples[i].kind != sample_sync) begin
                check_rgb(samples[i].h, samples[i].v);
            end
            if (samples[i].kind == sample_twin) begin
                assert ({red, grn, blu} === prev_rgb)
                    else report_mismatch("rgb of doubled pixel", prev_rgb, {red, grn, blu});
            end
            prev_rgb = {red, grn, blu};
        end

        // new name for the tile under (230, 165) chosen so that the pixel changes
        name_idx = (165 - top_border) / 16 * 32 + (230 - left_border) / 16;
        old_rgb  = model_rgb(230, 165);
        old_name = vram_copy[name_idx];
        new_name = old_name;
        found    = 1'b0;
        for (int k = 1; k < 256 && !found; k++) begin
            new_name            = old_name + vram_data_t'(k);
            vram_copy[name_idx] = new_name;
            found               = (model_rgb(230, 165) !== old_rgb);
        end
        vram_copy[name_idx] = old_name;
        if (!found) begin
            report_problem("no name byte changes the chosen pixel");
        end
        wait_until(frame_cycles + 505 * h_total);   // blanking lines of frame 1
        write_vram(name_idx, new_name);
        end_writes();
        wait_until(2 * frame_cycles + 165 * h_total + 230 + pipe_delay);
        check_rgb(230, 165);

        $display("Test OK");
        $finish;
    end

endmodule

// File: tile_display.f
+incdir+tests
common/vdp_pkg.sv
common/video_timing_if.sv
common/vram_read_if.sv
verilog/vga_timing.sv
vdp/vdp_tile_render.sv
vdp/vdp_vram.sv
verilog/tile_display.sv
tests/tile_display_tb.sv
